/* knight_pkg.sv */
/* Knight tour replay definitions.
   Tour size, move codes, headings, opcodes, responses and the command word layout. */
`default_nettype none

package knight_pkg;

  //////////////////////////////////////////////////////////////////////
  // Tour and board
  //////////////////////////////////////////////////////////////////////
  localparam int tour_moves  = 24;       // Moves in a full 5x5 tour.
  localparam int idx_w       = 5;        // Move index width.
  localparam int step_cycles = 4;        // Clocks spent on each square.

  typedef logic [2:0] pos_t;             // Board coordinate, wraps modulo 8.

  // One-hot move code, bit by bit:
  //   0: 2N 1E   1: 2N 1W   2: 1N 2W   3: 1S 2W
  //   4: 2S 1W   5: 2S 1E   6: 1S 2E   7: 1N 2E
  typedef logic [7:0] move_t;

  //////////////////////////////////////////////////////////////////////
  // Headings
  //////////////////////////////////////////////////////////////////////
  localparam logic [7:0] hd_north = 8'h00;  // Plus y.
  localparam logic [7:0] hd_west  = 8'h3F;  // Minus x.
  localparam logic [7:0] hd_south = 8'h7F;  // Minus y.
  localparam logic [7:0] hd_east  = 8'hBF;  // Plus x.

  //////////////////////////////////////////////////////////////////////
  // Opcodes and response codes
  //////////////////////////////////////////////////////////////////////
  localparam logic [3:0] op_set_pos  = 4'h1;  // Load x and y directly.
  localparam logic [3:0] op_move     = 4'h4;  // Move without fanfare.
  localparam logic [3:0] op_move_fan = 4'h5;  // Move, fanfare at the end.

  localparam logic [7:0] resp_done = 8'hA5;   // Tour finished or serial command.
  localparam logic [7:0] resp_busy = 8'h5A;   // Tour still running.

  // Command word, read as a move or as a set position.
  typedef union packed {
    struct packed {
      logic [3:0] opcode;                // Move or move with fanfare.
      logic [7:0] heading;               // One of the hd_ codes.
      logic [3:0] squares;               // Squares to travel.
    } mv;
    struct packed {
      logic [3:0] opcode;                // Set position.
      logic [5:0] spare;                 // Unused.
      pos_t       x;                     // New column.
      pos_t       y;                     // New row.
    } pos;
  } cmd_word_u;

endpackage

`default_nettype wire

/* cmd_bus_if.sv */
/* Command bus between the tour commander and the command executor.
   Level ready held until cleared, plus a response strobe. */
`timescale 1ns/1ns
`default_nettype none

interface cmd_bus_if;

  logic [15:0] cmd;                      // Command word.
  logic        cmd_rdy;                  // Held high until cleared.
  logic        clr_cmd_rdy;              // One clock, command taken.
  logic        send_resp;                // One clock, command finished.

  // Command source side.
  modport src (
    output cmd,
    output cmd_rdy,
    input  clr_cmd_rdy,
    input  send_resp
  );

  // Command executor side.
  modport sink (
    input  cmd,
    input  cmd_rdy,
    output clr_cmd_rdy,
    output send_resp
  );

endinterface

`default_nettype wire

/* move_store.sv */
/* Move store.
   Holds the loaded tour as one-hot moves, written by the host, read by index. */
`timescale 1ns/1ns
`default_nettype none

module move_store import knight_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             move_wr,      // Host write strobe.
  input  logic [idx_w-1:0] move_addr,    // Host write slot.
  input  move_t            move_data,    // Host move code.
  input  logic [idx_w-1:0] mv_indx,      // Replay read index.
  output move_t            move          // Move at the read index.
);

  move_t mem [tour_moves];               // One entry per tour move.
  logic  wr_ok;                          // Write slot inside the tour.
  logic  rd_ok;                          // Read index inside the tour.

  assign wr_ok = move_addr < idx_w'(tour_moves);
  assign rd_ok = mv_indx < idx_w'(tour_moves);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < tour_moves; i++)
        mem[i] <= '0;                    // Empty tour.
    end else if (move_wr && wr_ok) begin
      mem[move_addr] <= move_data;       // Single-cycle write.
    end
  end

  // Past the last move the index points nowhere, give no move.
  assign move = rd_ok ? mem[mv_indx] : '0;

endmodule

`default_nettype wire

/* move_decode.sv */
/* Move decoder.
   Splits a one-hot knight move into its vertical or horizontal leg. */
`timescale 1ns/1ns
`default_nettype none

module move_decode import knight_pkg::*; (
  input  move_t       move,              // One-hot move code.
  input  logic        horz_leg,          // High for the second leg.
  output logic [7:0]  heading,           // Leg heading.
  output logic [3:0]  squares            // Leg length.
);

  logic [7:0] vert_hd;                   // Vertical leg heading.
  logic [7:0] horz_hd;                   // Horizontal leg heading.
  logic [3:0] vert_sq;                   // Vertical leg length.
  logic [3:0] horz_sq;                   // Horizontal leg length.

  //////////////////////////////////////////////////////////////////////
  // Both legs of the move
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    unique case (1'b1)
      move[0]: begin                     // 2 north, 1 east.
        vert_hd = hd_north;
        vert_sq = 4'd2;
        horz_hd = hd_east;
        horz_sq = 4'd1;
      end
      move[1]: begin                     // 2 north, 1 west.
        vert_hd = hd_north;
        vert_sq = 4'd2;
        horz_hd = hd_west;
        horz_sq = 4'd1;
      end
      move[2]: begin                     // 1 north, 2 west.
        vert_hd = hd_north;
        vert_sq = 4'd1;
        horz_hd = hd_west;
        horz_sq = 4'd2;
      end
      move[3]: begin                     // 1 south, 2 west.
        vert_hd = hd_south;
        vert_sq = 4'd1;
        horz_hd = hd_west;
        horz_sq = 4'd2;
      end
      move[4]: begin                     // 2 south, 1 west.
        vert_hd = hd_south;
        vert_sq = 4'd2;
        horz_hd = hd_west;
        horz_sq = 4'd1;
      end
      move[5]: begin                     // 2 south, 1 east.
        vert_hd = hd_south;
        vert_sq = 4'd2;
        horz_hd = hd_east;
        horz_sq = 4'd1;
      end
      move[6]: begin                     // 1 south, 2 east.
        vert_hd = hd_south;
        vert_sq = 4'd1;
        horz_hd = hd_east;
        horz_sq = 4'd2;
      end
      move[7]: begin                     // 1 north, 2 east.
        vert_hd = hd_north;
        vert_sq = 4'd1;
        horz_hd = hd_east;
        horz_sq = 4'd2;
      end
      default: begin                     // Not one-hot, nothing defined.
        vert_hd = 'x;
        vert_sq = 'x;
        horz_hd = 'x;
        horz_sq = 'x;
      end
    endcase
  end

  // Pick the leg being replayed.
  assign heading = horz_leg ? horz_hd : vert_hd;
  assign squares = horz_leg ? horz_sq : vert_sq;

endmodule

`default_nettype wire

/* tour_cmd.sv */
/* Tour commander.
   Replays each stored move as a vertical then a horizontal command,
   sharing the command bus with the serial host. */
`timescale 1ns/1ns
`default_nettype none

module tour_cmd import knight_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start_tour,   // Pulse, begin replay.
  output logic [idx_w-1:0] mv_indx,      // Move being replayed.
  output logic             horz_leg,     // Second leg selected.
  input  logic [7:0]       heading,      // Decoded leg heading.
  input  logic [3:0]       squares,      // Decoded leg length.
  input  logic [15:0]      cmd_uart,     // Serial command.
  input  logic             cmd_rdy_uart, // Serial ready.
  cmd_bus_if.src           bus,          // Shared command bus.
  output logic [7:0]       resp          // Response code.
);

  enum logic [2:0] {IDLE, VERT, HOLDV, HORZ, HOLDH} state, nxt_state;

  logic      clr_index;                  // Restart at the first move.
  logic      inc_index;                  // Advance to the next move.
  logic      last_move;                  // Index at the final move.
  logic      tour_done;                  // Final leg answered.
  logic      cmd_rdy_tour;               // Commander ready.
  logic      own_bus;                    // Commander drives the bus.
  cmd_word_u tour_word;                  // Commander command word.

  //////////////////////////////////////////////////////////////////////
  // Move index
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      mv_indx <= '0;
    else if (clr_index)
      mv_indx <= '0;                     // New tour.
    else if (inc_index)
      mv_indx <= mv_indx + 1'b1;         // Both legs done.
  end

  assign last_move = mv_indx == idx_w'(tour_moves - 1);

  //////////////////////////////////////////////////////////////////////
  // Command word and bus mux
  //////////////////////////////////////////////////////////////////////
  assign horz_leg = (state == HORZ) || (state == HOLDH);
  assign own_bus  = state != IDLE;       // Serial side owns the bus in IDLE.

  always_comb begin
    tour_word.mv.opcode  = horz_leg ? op_move_fan : op_move;  // Fanfare closes the L.
    tour_word.mv.heading = heading;
    tour_word.mv.squares = squares;
  end

  assign bus.cmd     = own_bus ? tour_word : cmd_uart;
  assign bus.cmd_rdy = own_bus ? cmd_rdy_tour : cmd_rdy_uart;

  // Serial commands always answer done, tour legs busy until the last.
  assign resp = !own_bus  ? resp_done :
                tour_done ? resp_done : resp_busy;

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state    = state;
    clr_index    = 1'b0;
    inc_index    = 1'b0;
    tour_done    = 1'b0;
    cmd_rdy_tour = 1'b0;
    case (state)
      IDLE: begin
        if (start_tour) begin
          clr_index = 1'b1;              // Start from move 0.
          nxt_state = VERT;
        end
      end
      VERT: begin
        cmd_rdy_tour = 1'b1;             // Hold until taken.
        if (bus.clr_cmd_rdy)
          nxt_state = HOLDV;
      end
      HOLDV: begin
        if (bus.send_resp)
          nxt_state = HORZ;              // Second leg next cycle.
      end
      HORZ: begin
        cmd_rdy_tour = 1'b1;
        if (bus.clr_cmd_rdy)
          nxt_state = HOLDH;
      end
      HOLDH: begin
        if (bus.send_resp) begin
          inc_index = 1'b1;
          tour_done = last_move;         // Last leg of the tour.
          nxt_state = last_move ? IDLE : VERT;
        end
      end
      default: nxt_state = IDLE;
    endcase
  end

endmodule

`default_nettype wire

/* cmd_exec.sv */
/* Command executor.
   Takes one command at a time, walks the knight square by square and answers. */
`timescale 1ns/1ns
`default_nettype none

module cmd_exec import knight_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  cmd_bus_if.sink bus,                   // Shared command bus.
  output pos_t    pos_x,                 // Knight column.
  output pos_t    pos_y,                 // Knight row.
  output logic    fanfare                // Pulses with a fanfare move's response.
);

  cmd_word_u  cmd_q;                     // Accepted command.
  logic       busy;                      // Command in progress.
  logic       first;                     // First cycle after acceptance.
  logic [3:0] sq_left;                   // Squares still to walk.
  logic [3:0] step_tmr;                  // Clocks on the current square.
  logic       accept;                    // Take the offered command.
  logic       is_move;                   // Latched command is a move.
  logic       step_due;                  // Square time elapsed.

  assign accept   = !busy && bus.cmd_rdy;  // Ready ignored while busy.
  assign is_move  = (cmd_q.mv.opcode == op_move) || (cmd_q.mv.opcode == op_move_fan);
  assign step_due = step_tmr == 4'(step_cycles - 1);

  always_ff @(posedge clk) begin
    if (accept)
      cmd_q <= bus.cmd;                  // Latched with the acceptance edge.
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencing and position
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      busy            <= 1'b0;
      first           <= 1'b0;
      sq_left         <= '0;
      step_tmr        <= '0;
      bus.clr_cmd_rdy <= 1'b0;
      bus.send_resp   <= 1'b0;
      fanfare         <= 1'b0;
      pos_x           <= '0;             // Knight starts at (0,0).
      pos_y           <= '0;
    end else begin
      bus.clr_cmd_rdy <= 1'b0;           // Strobes last one clock.
      bus.send_resp   <= 1'b0;
      fanfare         <= 1'b0;
      if (accept) begin
        busy            <= 1'b1;
        first           <= 1'b1;
        bus.clr_cmd_rdy <= 1'b1;         // Tell the source it was taken.
      end else if (first) begin
        first    <= 1'b0;
        step_tmr <= '0;
        sq_left  <= cmd_q.mv.squares;
        if (!is_move) begin
          busy          <= 1'b0;         // Answer right away.
          bus.send_resp <= 1'b1;
          if (cmd_q.pos.opcode == op_set_pos) begin
            pos_x <= cmd_q.pos.x;
            pos_y <= cmd_q.pos.y;
          end
        end
      end else if (busy) begin
        step_tmr <= step_tmr + 4'd1;
        if (step_due) begin
          step_tmr <= '0;
          if (sq_left != 4'd0) begin
            sq_left <= sq_left - 4'd1;   // One square along the heading.
            case (cmd_q.mv.heading)
              hd_north: pos_y <= pos_y + 3'd1;
              hd_south: pos_y <= pos_y - 3'd1;
              hd_east:  pos_x <= pos_x + 3'd1;
              hd_west:  pos_x <= pos_x - 3'd1;
              default:  ;                // Unknown heading, stay put.
            endcase
          end else begin
            busy          <= 1'b0;       // Settled, respond.
            bus.send_resp <= 1'b1;
            fanfare       <= cmd_q.mv.opcode == op_move_fan;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* knight_top.sv */
/* Knight tour replay top.
   Move store, decoder, commander and executor on one command bus. */
`timescale 1ns/1ns
`default_nettype none

module knight_top import knight_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_tour,        // Pulse, replay the stored tour.
  input  logic        move_wr,           // Host move write strobe.
  input  logic [4:0]  move_addr,         // Host move slot.
  input  logic [7:0]  move_data,         // Host one-hot move.
  input  logic [15:0] cmd_uart,          // Serial command.
  input  logic        cmd_rdy_uart,      // Serial ready, held until cleared.
  output logic        clr_cmd_rdy,       // Command taken.
  output logic [7:0]  resp,              // Response code.
  output logic        resp_vld,          // Response strobe.
  output logic [2:0]  pos_x,             // Knight column.
  output logic [2:0]  pos_y,             // Knight row.
  output logic        fanfare            // Fanfare pulse.
);

  cmd_bus_if bus ();                     // Commander to executor.

  move_t            move;                // Stored move at the index.
  logic [idx_w-1:0] mv_indx;             // Replay index.
  logic             horz_leg;            // Second leg selected.
  logic [7:0]       heading;             // Decoded heading.
  logic [3:0]       squares;             // Decoded length.

  move_store u_store (
    .clk       (clk),
    .rst_n     (rst_n),
    .move_wr   (move_wr),
    .move_addr (move_addr),
    .move_data (move_data),
    .mv_indx   (mv_indx),
    .move      (move)
  );

  move_decode u_decode (
    .move     (move),
    .horz_leg (horz_leg),
    .heading  (heading),
    .squares  (squares)
  );

  tour_cmd u_tour (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_tour   (start_tour),
    .mv_indx      (mv_indx),
    .horz_leg     (horz_leg),
    .heading      (heading),
    .squares      (squares),
    .cmd_uart     (cmd_uart),
    .cmd_rdy_uart (cmd_rdy_uart),
    .bus          (bus.src),
    .resp         (resp)
  );

  cmd_exec u_exec (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus     (bus.sink),
    .pos_x   (pos_x),
    .pos_y   (pos_y),
    .fanfare (fanfare)
  );

  assign clr_cmd_rdy = bus.clr_cmd_rdy;  // Also seen by the serial side.
  assign resp_vld    = bus.send_resp;

endmodule

`default_nettype wire

/* tb_knight_tour.sv */
/* Knight tour replay testbench.
   Serial host model, tour table and a response scoreboard checked by assertions. */
`timescale 1ns/1ns
`default_nettype none

module tb_knight_tour import knight_pkg::*; ();

  // Two tours of 48 legs at 25 clocks at most each, plus serial commands and reset.
  localparam int timeout_cycles = 2 * 2 * tour_moves * 25 + 600;

  // Move deltas per one-hot bit, straight from the move table.
  localparam int dx_tab [8] = '{1, -1, -2, -2, -1, 1, 2, 2};
  localparam int dy_tab [8] = '{2, 2, 1, -1, -2, -2, -1, 1};

  // Open 5x5 tour from (0,0), ends on (2,2).
  localparam move_t tour_tab [tour_moves] = '{
    8'h80, 8'h40, 8'h02, 8'h01, 8'h08, 8'h04, 8'h20, 8'h20,
    8'h80, 8'h02, 8'h04, 8'h10, 8'h20, 8'h80, 8'h01, 8'h04,
    8'h08, 8'h20, 8'h40, 8'h01, 8'h02, 8'h08, 8'h10, 8'h80
  };

  logic        clk, rst_n, start_tour, move_wr;
  logic [4:0]  move_addr;
  logic [7:0]  move_data;
  logic [15:0] cmd_uart;
  logic        cmd_rdy_uart;
  logic        clr_cmd_rdy;
  logic [7:0]  resp;
  logic        resp_vld;
  logic [2:0]  pos_x, pos_y;
  logic        fanfare;

  pos_t       exp_x_a    [128];          // Expected position per response.
  pos_t       exp_y_a    [128];
  logic [7:0] exp_resp_a [128];          // Expected response code.
  logic       exp_fan_a  [128];          // Fanfare expected with it.

  int   n_exp      = 0;                  // Entries in the scoreboard.
  int   rsp_idx    = 0;                  // Responses seen.
  int   acc_idx    = 0;                  // Acceptances seen.
  int   fan_cnt    = 0;                  // Fanfare pulses seen.
  int   errors     = 0;
  int   cycles     = 0;
  int   tour_first = 1000;               // Scoreboard range of the running tour.
  int   tour_last  = -1;
  int   seed_ret;
  pos_t mdl_x, mdl_y;                    // Reference knight position.
  pos_t end_x, end_y;                    // Last square of the running tour.
  logic post_reset = 1'b0;               // First cycle out of reset.
  move_t rnd_tab [tour_moves];           // Random second tour.

  pos_t       cur_x, cur_y;
  logic [7:0] cur_resp;
  logic       cur_fan, tour_on;

  assign cur_x       = exp_x_a[rsp_idx];
  assign cur_y       = exp_y_a[rsp_idx];
  assign cur_resp    = exp_resp_a[rsp_idx];
  assign cur_fan     = exp_fan_a[rsp_idx];
  assign tour_on     = (rsp_idx >= tour_first) && (rsp_idx <= tour_last);

  knight_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_tour   (start_tour),
    .move_wr      (move_wr),
    .move_addr    (move_addr),
    .move_data    (move_data),
    .cmd_uart     (cmd_uart),
    .cmd_rdy_uart (cmd_rdy_uart),
    .clr_cmd_rdy  (clr_cmd_rdy),
    .resp         (resp),
    .resp_vld     (resp_vld),
    .pos_x        (pos_x),
    .pos_y        (pos_y),
    .fanfare      (fanfare)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;              // 20 ns period.
  end

  ////////////////////////////////////////////////////////////////////
  // Monitor and timeout
  ////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (rst_n) begin
      if (resp_vld)
        rsp_idx <= rsp_idx + 1;
      if (clr_cmd_rdy)
        acc_idx <= acc_idx + 1;
      if (fanfare)
        fan_cnt <= fan_cnt + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("Timeout, no end of test after %0d cycles", cycles);
      print_summary();
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////
  a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    post_reset |-> !clr_cmd_rdy && !resp_vld && !fanfare && pos_x == 3'd0 && pos_y == 3'd0)
    else begin
      errors = errors + 1;
      $display("CHECK FAILED clr_cmd_rdy=%h resp_vld=%h fanfare=%h pos_x=%h pos_y=%h",
               $sampled(clr_cmd_rdy), $sampled(resp_vld), $sampled(fanfare),
               $sampled(pos_x), $sampled(pos_y));
    end

  a_rsp_known: assert property (@(posedge clk) disable iff (!rst_n)
    resp_vld |-> rsp_idx < n_exp)
    else begin
      errors = errors + 1;
      $display("Response %0d arrived with no command outstanding", $sampled(rsp_idx));
    end

  a_rsp_pos: assert property (@(posedge clk) disable iff (!rst_n)
    resp_vld |-> pos_x == cur_x && pos_y == cur_y)
    else begin
      errors = errors + 1;
      $display("CHECK FAILED pos_x=%h pos_y=%h expected %h %h at response %0d",
               $sampled(pos_x), $sampled(pos_y), $sampled(cur_x), $sampled(cur_y),
               $sampled(rsp_idx));
    end

  a_rsp_code: assert property (@(posedge clk) disable iff (!rst_n)
    resp_vld |-> resp == cur_resp)
    else begin
      errors = errors + 1;
      $display("CHECK FAILED resp=%h expected %h at response %0d",
               $sampled(resp), $sampled(cur_resp), $sampled(rsp_idx));
    end

  a_fan_with_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    resp_vld |-> fanfare == cur_fan)
    else begin
      errors = errors + 1;
      $display("CHECK FAILED fanfare=%h expected %h at response %0d",
               $sampled(fanfare), $sampled(cur_fan), $sampled(rsp_idx));
    end

  a_fan_alone: assert property (@(posedge clk) disable iff (!rst_n)
    !resp_vld |-> !fanfare)
    else begin
      errors = errors + 1;
      $display("CHECK FAILED fanfare=%h without resp_vld", $sampled(fanfare));
    end

  a_one_out: assert property (@(posedge clk) disable iff (!rst_n)
    clr_cmd_rdy |-> acc_idx == rsp_idx)
    else begin
      errors = errors + 1;
      $display("Command taken while response %0d was still outstanding", $sampled(rsp_idx));
    end

  // Tour legs are taken two clocks after the previous answer or the start pulse.
  a_bus_owner: assert property (@(posedge clk) disable iff (!rst_n)
    clr_cmd_rdy && tour_on |-> $past(resp_vld, 2) || $past(start_tour, 2))
    else begin
      errors = errors + 1;
      $display("Command taken out of turn while a tour owned the bus");
    end

  a_tour_end: assert property (@(posedge clk) disable iff (!rst_n)
    resp_vld && rsp_idx == tour_last |-> pos_x == end_x && pos_y == end_y)
    else begin
      errors = errors + 1;
      $display("CHECK FAILED pos_x=%h pos_y=%h expected last square %h %h",
               $sampled(pos_x), $sampled(pos_y), $sampled(end_x), $sampled(end_y));
    end

  ////////////////////////////////////////////////////////////////////
  // Host and serial models
  ////////////////////////////////////////////////////////////////////
  task automatic expect_rsp(input pos_t x, input pos_t y, input logic [7:0] code,
                            input logic fan);
    exp_x_a[n_exp]    = x;
    exp_y_a[n_exp]    = y;
    exp_resp_a[n_exp] = code;
    exp_fan_a[n_exp]  = fan;
    n_exp             = n_exp + 1;
  endtask

  function automatic int hot_bit(input move_t m);
    int b;
    b = 0;
    for (int i = 0; i < 8; i++)
      if (m[i])
        b = i;
    return b;
  endfunction

  // Holds ready until its own command is taken, then waits for the answer.
  task automatic serial_cmd(input logic [15:0] word, input pos_t x, input pos_t y);
    int my_idx;
    my_idx = n_exp;
    mdl_x  = x;
    mdl_y  = y;
    expect_rsp(x, y, resp_done, 1'b0);
    @(posedge clk);
    cmd_uart     <= word;
    cmd_rdy_uart <= 1'b1;
    @(posedge clk);
    while (!(clr_cmd_rdy && acc_idx == my_idx))
      @(posedge clk);
    cmd_rdy_uart <= 1'b0;
    while (rsp_idx <= my_idx)
      @(posedge clk);
  endtask

  // Loads the store, predicts both legs of every move, starts the replay.
  task automatic run_tour(input move_t moves [tour_moves]);
    int b;
    tour_first = n_exp;
    for (int i = 0; i < tour_moves; i++) begin
      @(posedge clk);
      move_wr   <= 1'b1;
      move_addr <= 5'(i);
      move_data <= moves[i];
      b     = hot_bit(moves[i]);
      mdl_y = mdl_y + 3'(dy_tab[b]);     // Vertical leg first.
      expect_rsp(mdl_x, mdl_y, resp_busy, 1'b0);
      mdl_x = mdl_x + 3'(dx_tab[b]);
      expect_rsp(mdl_x, mdl_y, (i == tour_moves - 1) ? resp_done : resp_busy, 1'b1);
    end
    tour_last = n_exp - 1;
    @(posedge clk);
    move_wr    <= 1'b0;
    @(posedge clk);
    start_tour <= 1'b1;
    @(posedge clk);
    start_tour <= 1'b0;
  endtask

  task automatic print_summary();
    $display("Summary: %0d errors, %0d of %0d responses, %0d fanfare pulses",
             errors, rsp_idx, n_exp, fan_cnt);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////
  initial begin
    seed_ret     = $urandom(32'h107cc21a);
    rst_n        = 1'b0;
    start_tour   = 1'b0;
    move_wr      = 1'b0;
    move_addr    = '0;
    move_data    = '0;
    cmd_uart     = '0;
    cmd_rdy_uart = 1'b0;
    mdl_x        = '0;
    mdl_y        = '0;
    repeat (2) @(posedge clk);
    rst_n      <= 1'b1;
    post_reset <= 1'b1;                  // Quiet outputs checked next edge.
    @(posedge clk);
    post_reset <= 1'b0;

    serial_cmd({op_set_pos, 6'd0, 3'd2, 3'd3}, 3'd2, 3'd3);
    serial_cmd({op_move, hd_north, 4'd2}, 3'd2, 3'd5);
    serial_cmd({op_set_pos, 6'd0, 3'd0, 3'd0}, 3'd0, 3'd0);

    // Fixed tour with a serial command held across it.
    end_x = 3'd2;
    end_y = 3'd2;
    run_tour(tour_tab);
    serial_cmd({op_move, hd_east, 4'd1}, 3'd3, 3'd2);

    // Random one-hot moves, wrapping off the board.
    for (int i = 0; i < tour_moves; i++)
      rnd_tab[i] = 8'h01 << ($urandom() % 8);
    run_tour(rnd_tab);
    end_x = mdl_x;
    end_y = mdl_y;
    while (rsp_idx < n_exp)
      @(posedge clk);
    repeat (10) @(posedge clk);          // Room for any stray response.

    assert (rsp_idx == n_exp)
      else begin
        errors = errors + 1;
        $display("Saw %0d responses where %0d were due", rsp_idx, n_exp);
      end
    assert (fan_cnt == 2 * tour_moves)
      else begin
        errors = errors + 1;
        $display("Saw %0d fanfare pulses where %0d were due", fan_cnt, 2 * tour_moves);
      end

    print_summary();
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
knight_pkg.sv
cmd_bus_if.sv
move_store.sv
move_decode.sv
tour_cmd.sv
cmd_exec.sv
knight_top.sv
tb_knight_tour.sv

/* Bender.yml */
package:
  name: knight_tour

dependencies: {}

sources:
  # Design, in compile order.
  - knight_pkg.sv
  - cmd_bus_if.sv
  - move_store.sv
  - move_decode.sv
  - tour_cmd.sv
  - cmd_exec.sv
  - knight_top.sv

  # Testbench.
  - target: simulation
    files:
      - tb_knight_tour.sv
